/* axi_refill_master.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_refill_master (
    input  wire                                  clock,
    input  wire                                  reset_n,

    // line request from the cache core
    input  wire                                  refill_req_i,
    input  wire  [icache_pkg::addr_w-1:0]        refill_addr_i,
    output logic                                 refill_ack_o,

    // beat stream back to the core
    output logic                                 beat_valid_o,
    output logic [icache_pkg::data_w-1:0]        beat_data_o,
    output logic [icache_pkg::offset_w-1:0]      beat_idx_o,
    output logic                                 done_o,
    output logic                                 err_o,

    // AXI4 read address channel
    input  wire                                  axi_ar_ready_i,
    output logic                                 axi_ar_valid_o,
    output logic [icache_pkg::addr_w-1:0]        axi_ar_addr_o,
    output logic [7:0]                           axi_ar_len_o,
    output logic [2:0]                           axi_ar_size_o,
    output logic [1:0]                           axi_ar_burst_o,

    // AXI4 read data channel
    input  wire                                  axi_r_valid_i,
    input  wire  [icache_pkg::data_w-1:0]        axi_r_data_i,
    input  wire  [1:0]                           axi_r_resp_i,
    input  wire                                  axi_r_last_i,
    output logic                                 axi_r_ready_o
);

    icache_pkg::refill_state_t state_q;
    icache_pkg::refill_state_t state_d;

    // line address, held stable while ar_valid waits
    logic [icache_pkg::addr_w-1:0]   addr_q;
    // word offset of the next beat
    logic [icache_pkg::offset_w-1:0] beat_cnt_q;
    // sticky error over the burst
    logic                            err_q;

    logic req_take;
    logic ar_fire;
    logic beat_fire;
    logic beat_bad;

    // request taken only when no burst is running
    assign req_take  = (state_q == icache_pkg::refill_idle) && refill_req_i;
    assign ar_fire   = (state_q == icache_pkg::refill_addr) && axi_ar_ready_i;
    // r_ready is high for the whole data phase
    assign beat_fire = (state_q == icache_pkg::refill_data) && axi_r_valid_i;
    assign beat_bad  = (axi_r_resp_i != icache_pkg::axi_resp_okay);

    // idle -> addr -> data -> idle
    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::refill_idle: begin
                if (refill_req_i) begin
                    state_d = icache_pkg::refill_addr;
                end
            end
            icache_pkg::refill_addr: begin
                if (axi_ar_ready_i) begin
                    state_d = icache_pkg::refill_data;
                end
            end
            icache_pkg::refill_data: begin
                // leave on the last beat only
                if (axi_r_valid_i && axi_r_last_i) begin
                    state_d = icache_pkg::refill_idle;
                end
            end
            default: begin
                state_d = icache_pkg::refill_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= icache_pkg::refill_idle;
            beat_cnt_q <= '0;
            err_q      <= 1'b0;
        end else begin
            state_q <= state_d;
            // fresh count and error per burst
            if (ar_fire) begin
                beat_cnt_q <= '0;
                err_q      <= 1'b0;
            end else if (beat_fire) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                err_q      <= err_q | beat_bad;
            end
        end
    end

    // latch the line address on acceptance
    always_ff @(posedge clock) begin
        if (req_take) begin
            addr_q <= refill_addr_i;
        end
    end

    assign refill_ack_o = req_take;

    // beats go straight to the core, tagged with their offset
    assign beat_valid_o = beat_fire;
    assign beat_data_o  = axi_r_data_i;
    assign beat_idx_o   = beat_cnt_q;
    assign done_o       = beat_fire && axi_r_last_i;
    // include the last beat's own response
    assign err_o        = err_q | beat_bad;

    // AR channel, fixed burst shape
    assign axi_ar_valid_o = (state_q == icache_pkg::refill_addr);
    assign axi_ar_addr_o  = addr_q;
    assign axi_ar_len_o   = icache_pkg::axi_len;
    assign axi_ar_size_o  = icache_pkg::axi_size;
    assign axi_ar_burst_o = icache_pkg::axi_burst_incr;

    assign axi_r_ready_o  = (state_q == icache_pkg::refill_data);

endmodule

`default_nettype wire

/* icache_core.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_core (
    input  wire                                  clock,
    input  wire                                  reset_n,

    // fetch stage request
    input  wire                                  fetch_valid_i,
    input  wire  [icache_pkg::addr_w-1:0]        fetch_addr_i,
    output logic                                 fetch_ready_o,

    // fetch stage response, one cycle
    output logic                                 fetch_rvalid_o,
    output logic [icache_pkg::data_w-1:0]        fetch_data_o,
    output logic                                 fetch_err_o,

    // fence.i pulse
    input  wire                                  invalidate_i,

    // refill master handshake
    output logic                                 refill_req_o,
    output logic [icache_pkg::addr_w-1:0]        refill_addr_o,
    input  wire                                  refill_ack_i,

    // incoming line beats
    input  wire                                  beat_valid_i,
    input  wire  [icache_pkg::data_w-1:0]        beat_data_i,
    input  wire  [icache_pkg::offset_w-1:0]      beat_idx_i,
    input  wire                                  done_i,
    input  wire                                  err_i
);

    localparam int line_lo = icache_pkg::byte_w + icache_pkg::offset_w;
    localparam int words   = icache_pkg::line_count * icache_pkg::words_per_line;

    icache_pkg::fetch_state_t state_q;
    icache_pkg::fetch_state_t state_d;

    // arrays
    logic [icache_pkg::tag_w-1:0]    tag_q   [icache_pkg::line_count];
    logic [icache_pkg::line_count-1:0] valid_q;
    logic [icache_pkg::data_w-1:0]   data_q  [words];

    // request being served
    logic [icache_pkg::addr_w-1:0]   req_addr_q;
    logic [icache_pkg::tag_w-1:0]    req_tag;
    logic [icache_pkg::index_w-1:0]  req_index;
    logic [icache_pkg::offset_w-1:0] req_offset;

    // response payload
    logic [icache_pkg::data_w-1:0]   resp_data_q;
    logic                            err_q;

    // request already taken by the refill master
    logic                            acked_q;

    logic accept;
    logic hit;
    logic in_lookup;
    logic in_refill;
    logic line_done;

    // address fields
    assign req_tag    = req_addr_q[icache_pkg::addr_w-1 -: icache_pkg::tag_w];
    assign req_index  = req_addr_q[line_lo +: icache_pkg::index_w];
    assign req_offset = req_addr_q[icache_pkg::byte_w +: icache_pkg::offset_w];

    // invalidate takes the idle cycle, no accept then
    assign fetch_ready_o = (state_q == icache_pkg::fetch_idle) && !invalidate_i;
    assign accept        = fetch_valid_i && fetch_ready_o;

    assign in_lookup = (state_q == icache_pkg::fetch_lookup);
    assign in_refill = (state_q == icache_pkg::fetch_refill);
    assign line_done = in_refill && done_i;

    // tag compare
    assign hit = valid_q[req_index] && (tag_q[req_index] == req_tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::fetch_idle: begin
                if (accept) begin
                    state_d = icache_pkg::fetch_lookup;
                end
            end
            icache_pkg::fetch_lookup: begin
                // hit answers next cycle, miss goes to memory
                if (hit) begin
                    state_d = icache_pkg::fetch_respond;
                end else begin
                    state_d = icache_pkg::fetch_refill;
                end
            end
            icache_pkg::fetch_refill: begin
                if (done_i) begin
                    state_d = icache_pkg::fetch_respond;
                end
            end
            icache_pkg::fetch_respond: begin
                state_d = icache_pkg::fetch_idle;
            end
            default: begin
                state_d = icache_pkg::fetch_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= icache_pkg::fetch_idle;
            valid_q <= '0;
            acked_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;

            // fence.i drops every line
            if ((state_q == icache_pkg::fetch_idle) && invalidate_i) begin
                valid_q <= '0;
            end

            // failed burst leaves the line invalid, data is partly overwritten
            if (line_done) begin
                valid_q[req_index] <= !err_i;
            end

            // hold req until the master takes it
            if (line_done) begin
                acked_q <= 1'b0;
            end else if (in_refill && refill_ack_i) begin
                acked_q <= 1'b1;
            end

            if (in_lookup) begin
                err_q <= 1'b0;
            end else if (line_done) begin
                err_q <= err_i;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr_q <= fetch_addr_i;
        end

        // array read for the hit path
        if (in_lookup) begin
            resp_data_q <= data_q[{req_index, req_offset}];
        end

        // fill the line beat by beat, keep the requested word
        if (in_refill && beat_valid_i) begin
            data_q[{req_index, beat_idx_i}] <= beat_data_i;
            if (beat_idx_i == req_offset) begin
                resp_data_q <= beat_data_i;
            end
        end

        if (line_done && !err_i) begin
            tag_q[req_index] <= req_tag;
        end
    end

    // line-aligned refill address
    assign refill_req_o  = in_refill && !acked_q;
    assign refill_addr_o = {req_addr_q[icache_pkg::addr_w-1:line_lo], {line_lo{1'b0}}};

    assign fetch_rvalid_o = (state_q == icache_pkg::fetch_respond);
    assign fetch_data_o   = resp_data_q;
    assign fetch_err_o    = err_q;

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // fetch and bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // cache geometry, direct mapped
    localparam int words_per_line = 4;
    localparam int line_count     = 16;

    // address split: tag | index | word offset | byte offset
    localparam int byte_w   = $clog2(data_w / 8);
    localparam int offset_w = $clog2(words_per_line);
    localparam int index_w  = $clog2(line_count);
    localparam int tag_w    = addr_w - index_w - offset_w - byte_w;

    // one burst per line, one word per beat
    localparam logic [7:0] axi_len  = 8'(words_per_line - 1);
    localparam logic [2:0] axi_size = 3'(byte_w);

    // AXI burst and response codes
    localparam logic [1:0] axi_burst_incr = 2'b01;
    localparam logic [1:0] axi_resp_okay  = 2'b00;

    // refill master phases
    typedef enum logic [1:0] {
        refill_idle,
        refill_addr,
        refill_data
    } refill_state_t;

    // fetch controller phases
    typedef enum logic [1:0] {
        fetch_idle,
        fetch_lookup,
        fetch_refill,
        fetch_respond
    } fetch_state_t;

endpackage

`default_nettype wire

/* icache_subsys.f */
icache_pkg.sv
axi_refill_master.sv
icache_core.sv
icache_subsys.sv
tb_clock_gen.sv
tb_axi_mem.sv
tb_checker.sv
tb_icache.sv

/* icache_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_subsys (
    input  wire                                  clock,
    input  wire                                  reset_n,

    // fetch stage
    input  wire                                  fetch_valid_i,
    input  wire  [icache_pkg::addr_w-1:0]        fetch_addr_i,
    output logic                                 fetch_ready_o,
    output logic                                 fetch_rvalid_o,
    output logic [icache_pkg::data_w-1:0]        fetch_data_o,
    output logic                                 fetch_err_o,
    input  wire                                  invalidate_i,

    // AXI4 AR channel
    input  wire                                  axi_ar_ready_i,
    output logic                                 axi_ar_valid_o,
    output logic [icache_pkg::addr_w-1:0]        axi_ar_addr_o,
    output logic [7:0]                           axi_ar_len_o,
    output logic [2:0]                           axi_ar_size_o,
    output logic [1:0]                           axi_ar_burst_o,

    // AXI4 R channel
    input  wire                                  axi_r_valid_i,
    input  wire  [icache_pkg::data_w-1:0]        axi_r_data_i,
    input  wire  [1:0]                           axi_r_resp_i,
    input  wire                                  axi_r_last_i,
    output logic                                 axi_r_ready_o
);

    // core <-> refill master
    logic                              refill_req;
    logic [icache_pkg::addr_w-1:0]     refill_addr;
    logic                              refill_ack;
    logic                              beat_valid;
    logic [icache_pkg::data_w-1:0]     beat_data;
    logic [icache_pkg::offset_w-1:0]   beat_idx;
    logic                              refill_done;
    logic                              refill_err;

    icache_core u_core (
        .clock          (clock),
        .reset_n        (reset_n),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_addr_i   (fetch_addr_i),
        .fetch_ready_o  (fetch_ready_o),
        .fetch_rvalid_o (fetch_rvalid_o),
        .fetch_data_o   (fetch_data_o),
        .fetch_err_o    (fetch_err_o),
        .invalidate_i   (invalidate_i),
        .refill_req_o   (refill_req),
        .refill_addr_o  (refill_addr),
        .refill_ack_i   (refill_ack),
        .beat_valid_i   (beat_valid),
        .beat_data_i    (beat_data),
        .beat_idx_i     (beat_idx),
        .done_i         (refill_done),
        .err_i          (refill_err)
    );

    // one burst per missed line
    axi_refill_master u_refill (
        .clock          (clock),
        .reset_n        (reset_n),
        .refill_req_i   (refill_req),
        .refill_addr_i  (refill_addr),
        .refill_ack_o   (refill_ack),
        .beat_valid_o   (beat_valid),
        .beat_data_o    (beat_data),
        .beat_idx_o     (beat_idx),
        .done_o         (refill_done),
        .err_o          (refill_err),
        .axi_ar_ready_i (axi_ar_ready_i),
        .axi_ar_valid_o (axi_ar_valid_o),
        .axi_ar_addr_o  (axi_ar_addr_o),
        .axi_ar_len_o   (axi_ar_len_o),
        .axi_ar_size_o  (axi_ar_size_o),
        .axi_ar_burst_o (axi_ar_burst_o),
        .axi_r_valid_i  (axi_r_valid_i),
        .axi_r_data_i   (axi_r_data_i),
        .axi_r_resp_i   (axi_r_resp_i),
        .axi_r_last_i   (axi_r_last_i),
        .axi_r_ready_o  (axi_r_ready_o)
    );

endmodule

`default_nettype wire

/* tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem #(
    parameter logic [31:0] err_base = 32'h0000_0300
) (
    input  wire         clock,
    input  wire         reset_n,
    // stall bits from the stimulus LFSR
    input  wire         stall_ar_i,
    input  wire         stall_r_i,
    // AR channel
    input  wire         ar_valid_i,
    input  wire  [31:0] ar_addr_i,
    output logic        ar_ready_o,
    // R channel
    input  wire         r_ready_i,
    output logic        r_valid_o,
    output logic [31:0] r_data_o,
    output logic [1:0]  r_resp_o,
    output logic        r_last_o
);

    logic        busy;
    logic [31:0] base_q;
    logic [1:0]  beat_q;
    logic [31:0] beat_addr;

    // memory contents, fixed function of the byte address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    assign beat_addr = base_q + {beat_q, 2'b00};
    assign r_data_o  = word_at(beat_addr);
    assign r_last_o  = (beat_q == 2'd3);
    // SLVERR anywhere in the marked 64-byte region
    assign r_resp_o  = (beat_addr[31:6] == err_base[31:6]) ? 2'b10 : 2'b00;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            base_q     <= '0;
            beat_q     <= '0;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
        end else if (!busy) begin
            if (ar_valid_i && ar_ready_o) begin
                busy       <= 1'b1;
                base_q     <= ar_addr_i;
                beat_q     <= '0;
                ar_ready_o <= 1'b0;
                r_valid_o  <= !stall_r_i;
            end else begin
                // ready toggles randomly, with or without a request
                ar_ready_o <= !stall_ar_i;
            end
        end else if (r_valid_o && r_ready_i) begin
            if (r_last_o) begin
                busy      <= 1'b0;
                r_valid_o <= 1'b0;
            end else begin
                beat_q    <= beat_q + 2'd1;
                r_valid_o <= !stall_r_i;
            end
        end else if (!r_valid_o) begin
            // valid stays up until taken
            r_valid_o <= !stall_r_i;
        end
    end

endmodule

`default_nettype wire

/* tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter logic [31:0] err_base = 32'h0000_0300
) (
    input  wire         clock,
    input  wire         reset_n,
    // fetch side of the DUT
    input  wire         fetch_valid_i,
    input  wire  [31:0] fetch_addr_i,
    input  wire         fetch_ready_i,
    input  wire         fetch_rvalid_i,
    input  wire  [31:0] fetch_data_i,
    input  wire         fetch_err_i,
    input  wire         invalidate_i,
    // AXI side of the DUT
    input  wire         ar_valid_i,
    input  wire         ar_ready_i,
    input  wire  [31:0] ar_addr_i,
    input  wire  [7:0]  ar_len_i,
    input  wire  [2:0]  ar_size_i,
    input  wire  [1:0]  ar_burst_i,
    input  wire         r_ready_i,
    // running totals
    output int          errors_o,
    output int          misses_o,
    output int          bursts_o,
    output int          responses_o
);

    // reference tags and valid bits
    logic [23:0] tag_m [16];
    logic [15:0] valid_m;

    // the fetch in flight
    logic        busy;
    logic        exp_miss;
    logic        exp_err;
    logic [31:0] exp_data;
    logic [31:0] line_addr;
    int          accept_cycle;
    int          req_bursts;

    int          cycle = 0;
    int          errors = 0;
    int          misses = 0;
    int          bursts = 0;
    int          responses = 0;
    int          new_fails;
    logic        first_after_reset = 1'b0;

    assign errors_o    = errors;
    assign misses_o    = misses;
    assign bursts_o    = bursts;
    assign responses_o = responses;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic in_err(input logic [31:0] a);
        return a[31:6] == err_base[31:6];
    endfunction

    task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
        new_fails++;
    endtask

    task automatic fail_text(input string msg);
        $display("%0t ns: %s", $time, msg);
        new_fails++;
    endtask

    // control outputs that must be low around reset
    task automatic check_quiet;
        if (fetch_rvalid_i !== 1'b0) fail_value("fetch_rvalid_o", 0, fetch_rvalid_i);
        if (ar_valid_i !== 1'b0) fail_value("axi_ar_valid_o", 0, ar_valid_i);
        if (r_ready_i !== 1'b0) fail_value("axi_r_ready_o", 0, r_ready_i);
    endtask

    always @(posedge clock) begin : monitor
        logic [3:0] idx;
        logic       hit_m;
        new_fails = 0;
        // 16 lines of 16 bytes with the tag above bit 7
        idx   = fetch_addr_i[7:4];
        hit_m = valid_m[idx] && (tag_m[idx] == fetch_addr_i[31:8]);
        cycle <= cycle + 1;
        if (!reset_n) begin
            valid_m           <= '0;
            busy              <= 1'b0;
            first_after_reset <= 1'b1;
            // the async reset may only act on this first edge
            if (cycle != 0) begin
                check_quiet();
            end
        end else begin
            if (first_after_reset) begin
                check_quiet();
                if (fetch_ready_i !== 1'b1) fail_value("fetch_ready_o", 1, fetch_ready_i);
                first_after_reset <= 1'b0;
            end
            // fence.i only lands while idle
            if (invalidate_i && !busy) begin
                valid_m <= '0;
                if (fetch_ready_i !== 1'b0) fail_value("fetch_ready_o", 0, fetch_ready_i);
            end
            if (fetch_valid_i && fetch_ready_i) begin
                busy         <= 1'b1;
                exp_miss     <= !hit_m;
                exp_err      <= !hit_m && in_err(fetch_addr_i);
                exp_data     <= word_at({fetch_addr_i[31:2], 2'b00});
                line_addr    <= {fetch_addr_i[31:4], 4'h0};
                accept_cycle <= cycle;
                req_bursts   <= 0;
                if (!hit_m) begin
                    misses <= misses + 1;
                    // a failed burst overwrites the line and leaves it invalid
                    if (in_err(fetch_addr_i)) begin
                        valid_m[idx] <= 1'b0;
                    end else begin
                        valid_m[idx] <= 1'b1;
                        tag_m[idx]   <= fetch_addr_i[31:8];
                    end
                end
            end
            if (ar_valid_i && ar_ready_i) begin
                bursts     <= bursts + 1;
                req_bursts <= req_bursts + 1;
                if (!busy) fail_text("AR handshake with no fetch outstanding");
                if (ar_addr_i !== line_addr) fail_value("axi_ar_addr_o", line_addr, ar_addr_i);
                if (ar_len_i !== 8'd3) fail_value("axi_ar_len_o", 3, ar_len_i);
                if (ar_size_i !== 3'd2) fail_value("axi_ar_size_o", 2, ar_size_i);
                if (ar_burst_i !== 2'b01) fail_value("axi_ar_burst_o", 1, ar_burst_i);
            end
            if (fetch_rvalid_i) begin
                if (!busy) begin
                    fail_text("fetch response with no fetch outstanding");
                end else begin
                    responses <= responses + 1;
                    busy      <= 1'b0;
                    if (fetch_err_i !== exp_err) fail_value("fetch_err_o", exp_err, fetch_err_i);
                    if (!exp_err && fetch_data_i !== exp_data) begin
                        fail_value("fetch_data_o", exp_data, fetch_data_i);
                    end
                    if (req_bursts != int'(exp_miss)) begin
                        fail_value("axi_ar_valid_o handshakes", exp_miss, req_bursts);
                    end
                    // hit answers two edges after acceptance
                    if (!exp_miss && cycle - accept_cycle != 2) begin
                        fail_value("fetch_rvalid_o hit latency", 2, cycle - accept_cycle);
                    end
                end
            end
        end
        errors <= errors + new_fails;
    end

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic reset_n_o
);

    // 100 ns period
    initial begin
        clock_o = 1'b0;
        forever #50 clock_o = ~clock_o;
    end

    // reset held low for 5 rising edges
    initial begin
        reset_n_o = 1'b0;
        repeat (5) @(posedge clock_o);
        reset_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam logic [31:0] err_base = 32'h0000_0300;
    localparam int wait_limit = 300;

    logic        clock;
    logic        reset_n;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        fetch_ready;
    logic        fetch_rvalid;
    logic [31:0] fetch_data;
    logic        fetch_err;
    logic        invalidate;
    logic        ar_ready;
    logic        ar_valid;
    logic [31:0] ar_addr;
    logic [7:0]  ar_len;
    logic [2:0]  ar_size;
    logic [1:0]  ar_burst;
    logic        r_valid;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
    logic        r_last;
    logic        r_ready;
    logic        stall_ar;
    logic        stall_r;

    int          chk_errors;
    int          misses;
    int          bursts;
    int          responses;
    int          tb_fails = 0;
    int          fails_before;
    int          bursts_before;
    logic [15:0] lfsr_q = 16'd20;
    logic [31:0] rnd;

    tb_clock_gen u_clock (.clock_o(clock), .reset_n_o(reset_n));

    icache_subsys uut (
        .clock          (clock),
        .reset_n        (reset_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_addr_i   (fetch_addr),
        .fetch_ready_o  (fetch_ready),
        .fetch_rvalid_o (fetch_rvalid),
        .fetch_data_o   (fetch_data),
        .fetch_err_o    (fetch_err),
        .invalidate_i   (invalidate),
        .axi_ar_ready_i (ar_ready),
        .axi_ar_valid_o (ar_valid),
        .axi_ar_addr_o  (ar_addr),
        .axi_ar_len_o   (ar_len),
        .axi_ar_size_o  (ar_size),
        .axi_ar_burst_o (ar_burst),
        .axi_r_valid_i  (r_valid),
        .axi_r_data_i   (r_data),
        .axi_r_resp_i   (r_resp),
        .axi_r_last_i   (r_last),
        .axi_r_ready_o  (r_ready)
    );

    tb_axi_mem #(.err_base(err_base)) u_mem (
        .clock      (clock),
        .reset_n    (reset_n),
        .stall_ar_i (stall_ar),
        .stall_r_i  (stall_r),
        .ar_valid_i (ar_valid),
        .ar_addr_i  (ar_addr),
        .ar_ready_o (ar_ready),
        .r_ready_i  (r_ready),
        .r_valid_o  (r_valid),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_last_o   (r_last)
    );

    tb_checker #(.err_base(err_base)) u_check (
        .clock          (clock),
        .reset_n        (reset_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_addr_i   (fetch_addr),
        .fetch_ready_i  (fetch_ready),
        .fetch_rvalid_i (fetch_rvalid),
        .fetch_data_i   (fetch_data),
        .fetch_err_i    (fetch_err),
        .invalidate_i   (invalidate),
        .ar_valid_i     (ar_valid),
        .ar_ready_i     (ar_ready),
        .ar_addr_i      (ar_addr),
        .ar_len_i       (ar_len),
        .ar_size_i      (ar_size),
        .ar_burst_i     (ar_burst),
        .r_ready_i      (r_ready),
        .errors_o       (chk_errors),
        .misses_o       (misses),
        .bursts_o       (bursts),
        .responses_o    (responses)
    );

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // shift n fresh LFSR bits into v
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // advance one clock and redraw the AXI stall bits
    task automatic tick;
        logic [31:0] b;
        @(posedge clock);
        rand_bits(2, b);
        stall_ar <= b[0];
        stall_r  <= b[1];
    endtask

    task automatic timeout(input string what);
        $display("%0t ns: timed out waiting for %s", $time, what);
        tb_fails++;
    endtask

    // request then wait for accept and response
    task automatic fetch(input logic [31:0] addr);
        int n;
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        n = 0;
        tick();
        while (!fetch_ready && n < wait_limit) begin
            n++;
            tick();
        end
        fetch_valid <= 1'b0;
        if (!fetch_ready) begin
            timeout("fetch_ready_o");
        end else begin
            n = 0;
            tick();
            while (!fetch_rvalid && n < wait_limit) begin
                n++;
                tick();
            end
            if (!fetch_rvalid) timeout("fetch_rvalid_o");
        end
    endtask

    // fence.i pulse once the core is idle
    task automatic flush;
        int n;
        n = 0;
        tick();
        while (!fetch_ready && n < wait_limit) begin
            n++;
            tick();
        end
        if (!fetch_ready) timeout("idle before invalidate");
        invalidate <= 1'b1;
        tick();
        invalidate <= 1'b0;
    endtask

    task automatic begin_test;
        tick();
        fails_before  = chk_errors + tb_fails;
        bursts_before = bursts;
    endtask

    // negative exp_bursts skips the burst count check
    task automatic end_test(input string name, input int exp_bursts);
        tick();
        if (exp_bursts >= 0 && bursts - bursts_before != exp_bursts) begin
            $display("[FAIL] %0t ns axi_ar_valid_o handshakes expected %0d got %0d",
                     $time, exp_bursts, bursts - bursts_before);
            tb_fails++;
        end
        $display("test %s: %0d errors", name, chk_errors + tb_fails - fails_before);
    endtask

    initial begin
        int n;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        invalidate  = 1'b0;
        stall_ar    = 1'b0;
        stall_r     = 1'b0;

        n = 0;
        tick();
        while (!reset_n && n < wait_limit) begin
            n++;
            tick();
        end
        if (!reset_n) timeout("end of reset");

        // cold cache so the first fetch must miss
        begin_test();
        fetch(32'h0000_0020);
        end_test("reset state", 1);

        begin_test();
        fetch(32'h0000_0048);
        fetch(32'h0000_004C);
        end_test("miss then hit", 1);

        // index 0xA with tags 0 and 1
        begin_test();
        repeat (3) begin
            fetch(32'h0000_00A4);
            fetch(32'h0000_01A8);
        end
        end_test("conflict replacement", 6);

        // 1 KB window holding four tags per index and the error region
        begin_test();
        for (int i = 0; i < 400; i++) begin
            rand_bits(8, rnd);
            fetch({22'b0, rnd[7:0], 2'b00});
        end
        tick();
        if (bursts != misses) begin
            $display("[FAIL] %0t ns axi_ar_valid_o handshakes expected %0d got %0d",
                     $time, misses, bursts);
            tb_fails++;
        end
        end_test("random traffic", -1);

        // same line twice since it never gets installed
        begin_test();
        fetch(err_base + 32'h14);
        fetch(err_base + 32'h18);
        end_test("error response", 2);

        fetch(32'h0000_0054);
        begin_test();
        flush();
        fetch(32'h0000_0058);
        end_test("invalidate", 1);

        tick();
        $display("tests 6, responses %0d, misses %0d, bursts %0d, errors %0d",
                 responses, misses, bursts, chk_errors + tb_fails);
        if (chk_errors + tb_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
